//--- hdl/bus_map_pkg.sv
// Settings and readback bus map for the bus control block
// Addresses are 8 bits and data is 32 bits on both buses

package bus_map_pkg;

   // ------------------------------------------------------------
   // Bus widths and types
   // ------------------------------------------------------------
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int RB_ADDR_W  = 8;
   localparam int RB_DATA_W  = 32;

   typedef logic [SET_ADDR_W-1:0] set_addr_t;
   typedef logic [SET_DATA_W-1:0] set_data_t;
   typedef logic [RB_ADDR_W-1:0]  rb_addr_t;
   typedef logic [RB_DATA_W-1:0]  rb_data_t;

   // Register field types
   typedef logic [7:0] leds_t;
   typedef logic [3:0] sw_rst_t;
   typedef logic [7:0] clock_ctrl_t;
   typedef logic [7:0] clock_status_t;
   typedef logic [1:0] sfpp_ctrl_t;

   // ------------------------------------------------------------
   // Settings addresses
   // ------------------------------------------------------------
   localparam set_addr_t SR_LEDS       = 8'd0;
   localparam set_addr_t SR_SW_RST     = 8'd1;
   localparam set_addr_t SR_CLOCK_CTRL = 8'd2;
   localparam set_addr_t SR_SFPP_CTRL0 = 8'd8;
   localparam set_addr_t SR_SFPP_CTRL1 = 8'd9;

   // Readback addresses
   localparam rb_addr_t RB_COUNTER      = 8'd0;
   localparam rb_addr_t RB_CLK_STATUS   = 8'd3;
   localparam rb_addr_t RB_COMPAT_NUM   = 8'd6;
   localparam rb_addr_t RB_SFPP_STATUS0 = 8'd8;
   localparam rb_addr_t RB_SFPP_STATUS1 = 8'd9;

   localparam logic [15:0] COMPAT_MAJOR = 16'h0020;
   localparam logic [15:0] COMPAT_MINOR = 16'h0000;

   // Reset values with the GPS-disciplined oscillator on (bit 6)
   localparam leds_t       LEDS_RESET       = 8'h00;
   localparam sw_rst_t     SW_RST_RESET     = 4'h0;
   localparam clock_ctrl_t CLOCK_CTRL_RESET = 8'h40;
   localparam sfpp_ctrl_t  SFPP_CTRL_RESET  = 2'b00;

endpackage

//--- hdl/sfp_pkg.sv
// SFP port definitions shared by the monitors and the readback side
// Pin group bit 2 is module absent, bit 1 transmit fault, bit 0 receive loss

package sfp_pkg;

   // Number of SFP ports on the board
   localparam int NUM_SFP = 2;

   // Flops in each synchronizer chain
   localparam int SYNC_STAGES = 2;

   // ------------------------------------------------------------
   // Pin and PHY status types
   // ------------------------------------------------------------
   typedef logic [2:0]  sfp_pins_t;
   typedef logic [15:0] phy_status_t;

   // ------------------------------------------------------------
   // Status word layout
   // ------------------------------------------------------------
   // PHY status in the top half
   localparam int STAT_PHY_LSB  = 16;
   // Sticky change bits above the live pins
   localparam int STAT_CHGD_LSB = 3;
   localparam int STAT_PINS_LSB = 0;

   // All other status word bits read as zero

endpackage

//--- hdl/sfp_status_if.sv
// One SFP port's synchronized status from its monitor to the readback mux
// All signals live in the clk domain

interface sfp_status_if
   import sfp_pkg::*;
();

   // Pins after the synchronizer
   sfp_pins_t   pins_sync;
   // Sticky per-pin change flags
   sfp_pins_t   pins_chgd;
   phy_status_t phy_sync;

   // One-cycle pulse from a read of this port's status word
   logic        rd_clear;

   modport monitor (
      output pins_sync,
      output pins_chgd,
      output phy_sync,
      input  rd_clear
   );

   modport reader (
      input  pins_sync,
      input  pins_chgd,
      input  phy_sync,
      output rd_clear
   );

endinterface

//--- hdl/setting_regs.sv
// Writable configuration registers on the settings bus
// A write lands one cycle after the strobe edge; unmapped addresses are ignored

module setting_regs
   import bus_map_pkg::*;
(
   input  logic        clk,
   input  logic        i_arst_n,

   // Settings bus
   input  logic        i_set_stb,
   input  set_addr_t   i_set_addr,
   input  set_data_t   i_set_data,

   // Register outputs
   output leds_t       o_leds,
   output sw_rst_t     o_sw_rst,
   output clock_ctrl_t o_clock_control,
   output sfpp_ctrl_t  o_sfp0_rs_pull_low,
   output sfpp_ctrl_t  o_sfp1_rs_pull_low
);

   // ------------------------------------------------------------
   // Address decode and register update
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_leds             <= LEDS_RESET;
         o_sw_rst           <= SW_RST_RESET;
         o_clock_control    <= CLOCK_CTRL_RESET;
         o_sfp0_rs_pull_low <= SFPP_CTRL_RESET;
         o_sfp1_rs_pull_low <= SFPP_CTRL_RESET;
      end else if (i_set_stb) begin
         case (i_set_addr)
            SR_LEDS: begin
               o_leds <= i_set_data[$bits(leds_t)-1:0];
            end
            // Bit 0 PHY, bit 1 radio domain, bit 2 radio PLL, bit 3 IDELAYCTRL
            SR_SW_RST: begin
               o_sw_rst <= i_set_data[$bits(sw_rst_t)-1:0];
            end
            SR_CLOCK_CTRL: begin
               o_clock_control <= i_set_data[$bits(clock_ctrl_t)-1:0];
            end
            // A set bit pulls the open-drain rate select pin low
            SR_SFPP_CTRL0: begin
               o_sfp0_rs_pull_low <= i_set_data[$bits(sfpp_ctrl_t)-1:0];
            end
            SR_SFPP_CTRL1: begin
               o_sfp1_rs_pull_low <= i_set_data[$bits(sfpp_ctrl_t)-1:0];
            end
            default: begin
               // Other addresses belong to blocks outside this one
            end
         endcase
      end
   end

endmodule

//--- hdl/sfp_monitor.sv
// Synchronizes one SFP port's pins and PHY status into clk
// Pin changes set sticky flags, cleared by a read of the port's status word

module sfp_monitor
   import sfp_pkg::*;
(
   input  logic        clk,
   input  logic        i_arst_n,

   // Asynchronous module pins and PHY status
   input  sfp_pins_t   i_pins,
   input  phy_status_t i_phy_status,

   sfp_status_if.monitor stat
);

   // Pins and PHY bits share one synchronizer chain
   logic [SYNC_STAGES-1:0][$bits(sfp_pins_t)+$bits(phy_status_t)-1:0] sync_q;

   sfp_pins_t   pins_sync;
   sfp_pins_t   pins_prev;
   sfp_pins_t   pins_chgd;
   phy_status_t phy_sync;

   // ------------------------------------------------------------
   // Synchronizer chain
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], {i_pins, i_phy_status}};
      end
   end

   assign {pins_sync, phy_sync} = sync_q[SYNC_STAGES-1];

   // ------------------------------------------------------------
   // Change detect and sticky latch
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pins_prev <= '0;
         pins_chgd <= '0;
      end else begin
         pins_prev <= pins_sync;
         // Clear has priority over a change in the same cycle
         if (stat.rd_clear) begin
            pins_chgd <= '0;
         end else begin
            pins_chgd <= pins_chgd | (pins_sync ^ pins_prev);
         end
      end
   end

   assign stat.pins_sync = pins_sync;
   assign stat.pins_chgd = pins_chgd;
   assign stat.phy_sync  = phy_sync;

endmodule

//--- hdl/readback_mux.sv
// Readback word select that is combinational from the address in the same cycle
// Unknown addresses read zero; reads never stall

module readback_mux
   import bus_map_pkg::*;
   import sfp_pkg::*;
(
   input  logic          clk,
   input  logic          i_arst_n,

   // Readback bus
   input  logic          i_rb_rd_stb,
   input  rb_addr_t      i_rb_addr,
   output rb_data_t      o_rb_data,

   input  clock_status_t i_clock_status,

   // Per-port SFP status
   sfp_status_if.reader  stat0,
   sfp_status_if.reader  stat1
);

   rb_data_t counter;

   // Pack one port's status word
   function automatic rb_data_t status_word(
      input sfp_pins_t   pins,
      input sfp_pins_t   chgd,
      input phy_status_t phy
   );
      rb_data_t word;
      word = '0;
      word[STAT_PHY_LSB +: $bits(phy_status_t)] = phy;
      word[STAT_CHGD_LSB +: $bits(sfp_pins_t)]  = chgd;
      word[STAT_PINS_LSB +: $bits(sfp_pins_t)]  = pins;
      return word;
   endfunction

   // ------------------------------------------------------------
   // Free running cycle counter
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   // ------------------------------------------------------------
   // Word select
   // ------------------------------------------------------------
   always_comb begin
      case (i_rb_addr)
         RB_COUNTER:      o_rb_data = counter;
         RB_CLK_STATUS:   o_rb_data = rb_data_t'(i_clock_status);
         RB_COMPAT_NUM:   o_rb_data = {COMPAT_MAJOR, COMPAT_MINOR};
         RB_SFPP_STATUS0: o_rb_data = status_word(stat0.pins_sync, stat0.pins_chgd,
                                                  stat0.phy_sync);
         RB_SFPP_STATUS1: o_rb_data = status_word(stat1.pins_sync, stat1.pins_chgd,
                                                  stat1.phy_sync);
         default:         o_rb_data = '0;
      endcase
   end

   // Read of a status word clears that port's change flags
   assign stat0.rd_clear = i_rb_rd_stb && (i_rb_addr == RB_SFPP_STATUS0);
   assign stat1.rd_clear = i_rb_rd_stb && (i_rb_addr == RB_SFPP_STATUS1);

endmodule

//--- hdl/bus_ctrl_top.sv
// Register side of the radio's bus interface with settings and readback buses
// SFP pins and PHY status are asynchronous and get synchronized inside

module bus_ctrl_top
   import bus_map_pkg::*;
   import sfp_pkg::*;
(
   input  logic          clk,
   input  logic          i_arst_n,

   // Settings bus
   input  logic          i_set_stb,
   input  set_addr_t     i_set_addr,
   input  set_data_t     i_set_data,

   // Readback bus
   input  logic          i_rb_rd_stb,
   input  rb_addr_t      i_rb_addr,
   output rb_data_t      o_rb_data,

   // Clock board status and control
   input  clock_status_t i_clock_status,
   output clock_ctrl_t   o_clock_control,

   // SFP pins and PHY status
   input  sfp_pins_t     i_sfp0_pins,
   input  sfp_pins_t     i_sfp1_pins,
   input  phy_status_t   i_sfp0_phy_status,
   input  phy_status_t   i_sfp1_phy_status,

   output leds_t         o_leds,
   output sw_rst_t       o_sw_rst,
   output sfpp_ctrl_t    o_sfp0_rs_pull_low,
   output sfpp_ctrl_t    o_sfp1_rs_pull_low
);

   sfp_status_if stat_if [NUM_SFP] ();

   // ------------------------------------------------------------
   // Configuration registers
   // ------------------------------------------------------------
   setting_regs setting_regs_i (
      .clk                (clk),
      .i_arst_n           (i_arst_n),
      .i_set_stb          (i_set_stb),
      .i_set_addr         (i_set_addr),
      .i_set_data         (i_set_data),
      .o_leds             (o_leds),
      .o_sw_rst           (o_sw_rst),
      .o_clock_control    (o_clock_control),
      .o_sfp0_rs_pull_low (o_sfp0_rs_pull_low),
      .o_sfp1_rs_pull_low (o_sfp1_rs_pull_low)
   );

   // ------------------------------------------------------------
   // SFP monitors
   // ------------------------------------------------------------
   sfp_monitor sfp0_mon_i (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_pins       (i_sfp0_pins),
      .i_phy_status (i_sfp0_phy_status),
      .stat         (stat_if[0])
   );

   sfp_monitor sfp1_mon_i (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_pins       (i_sfp1_pins),
      .i_phy_status (i_sfp1_phy_status),
      .stat         (stat_if[1])
   );

   // Readback select and read-clear decode
   readback_mux readback_mux_i (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_rb_rd_stb    (i_rb_rd_stb),
      .i_rb_addr      (i_rb_addr),
      .o_rb_data      (o_rb_data),
      .i_clock_status (i_clock_status),
      .stat0          (stat_if[0]),
      .stat1          (stat_if[1])
   );

endmodule

//--- sim/tb_clkgen.sv
// Clock and reset source for the testbench with an 8 ns period
// Reset drops shortly after time zero and is held low for 4 rising edges

module tb_clkgen (
   output logic o_clk,
   output logic o_arst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES = 4;

   initial begin
      o_clk = 1'b0;
      forever #4 o_clk = ~o_clk;
   end

   // Real falling edge on reset so the async reset branch runs
   initial begin
      o_arst_n = 1'b1;
      #1 o_arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_arst_n <= 1'b1;
   end

endmodule

//--- sim/bus_ctrl_checker.sv
// Concurrent checks on bus_ctrl_top that are attached by bind
// Change bits are taken from inside the two SFP monitors

module bus_ctrl_checker
   import bus_map_pkg::*;
   import sfp_pkg::*;
(
   input logic        clk,
   input logic        i_arst_n,
   input logic        i_set_stb,
   input logic        i_rb_rd_stb,
   input rb_addr_t    i_rb_addr,
   input clock_ctrl_t i_clock_control,
   // All register outputs side by side
   input logic [23:0] i_regs,
   input sfp_pins_t   i_sfp0_chgd,
   input sfp_pins_t   i_sfp1_chgd
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;

   // ------------------------------------------------------------
   // Register rules
   // ------------------------------------------------------------
   a_clock_ctrl_reset: assert property (@(posedge clk) !i_arst_n |-> i_clock_control == 8'h40)
      else begin fail_count++; $error("clock control not 0x40 during reset"); end

   a_regs_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      !i_set_stb |=> $stable(i_regs))
      else begin fail_count++; $error("register output changed without a write"); end

   // ------------------------------------------------------------
   // Read clear of the sticky change bits
   // ------------------------------------------------------------
   a_sfp0_clear: assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_rb_rd_stb && i_rb_addr == RB_SFPP_STATUS0) |=> i_sfp0_chgd == '0)
      else begin fail_count++; $error("SFP0 change bits not cleared by read"); end

   a_sfp1_clear: assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_rb_rd_stb && i_rb_addr == RB_SFPP_STATUS1) |=> i_sfp1_chgd == '0)
      else begin fail_count++; $error("SFP1 change bits not cleared by read"); end

endmodule

bind bus_ctrl_top bus_ctrl_checker bus_ctrl_checker_i (
   .clk             (clk),
   .i_arst_n        (i_arst_n),
   .i_set_stb       (i_set_stb),
   .i_rb_rd_stb     (i_rb_rd_stb),
   .i_rb_addr       (i_rb_addr),
   .i_clock_control (o_clock_control),
   .i_regs          ({o_leds, o_sw_rst, o_clock_control, o_sfp0_rs_pull_low, o_sfp1_rs_pull_low}),
   .i_sfp0_chgd     (sfp0_mon_i.pins_chgd),
   .i_sfp1_chgd     (sfp1_mon_i.pins_chgd)
);

//--- sim/tb_top.sv
// Random testbench for bus_ctrl_top against a register and SFP status model
// Inputs change on the rising edge and outputs are sampled on the falling edge

module tb_top
   import bus_map_pkg::*;
   import sfp_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] SEED = 32'h0c597e37;
   localparam int RESET_TIMEOUT = 50;
   localparam set_addr_t SET_MAP [5] = '{SR_LEDS, SR_SW_RST, SR_CLOCK_CTRL,
                                         SR_SFPP_CTRL0, SR_SFPP_CTRL1};

   logic clk, arst_n, set_stb, rb_rd_stb;
   set_addr_t set_addr;
   set_data_t set_data;
   rb_addr_t rb_addr;
   rb_data_t rb_data;
   clock_status_t clock_status;
   sfp_pins_t sfp0_pins, sfp1_pins;
   phy_status_t sfp0_phy, sfp1_phy;
   leds_t leds;
   sw_rst_t sw_rst;
   clock_ctrl_t clock_control;
   sfpp_ctrl_t sfp0_rs, sfp1_rs;

   // Reference model
   leds_t m_leds = 8'h00;
   sw_rst_t m_sw_rst = 4'h0;
   clock_ctrl_t m_clock_control = 8'h40;
   sfpp_ctrl_t m_sfp0_rs = 2'b00;
   sfpp_ctrl_t m_sfp1_rs = 2'b00;
   sfp_pins_t m_pins [NUM_SFP] = '{default: '0};
   sfp_pins_t m_chgd [NUM_SFP] = '{default: '0};
   phy_status_t m_phy [NUM_SFP] = '{default: '0};
   int errors = 0;

   tb_clkgen tb_clkgen_i (.o_clk(clk), .o_arst_n(arst_n));

   bus_ctrl_top bus_ctrl_top_i (
      .clk(clk), .i_arst_n(arst_n), .i_set_stb(set_stb), .i_set_addr(set_addr),
      .i_set_data(set_data), .i_rb_rd_stb(rb_rd_stb), .i_rb_addr(rb_addr),
      .o_rb_data(rb_data), .i_clock_status(clock_status), .o_clock_control(clock_control),
      .i_sfp0_pins(sfp0_pins), .i_sfp1_pins(sfp1_pins), .i_sfp0_phy_status(sfp0_phy),
      .i_sfp1_phy_status(sfp1_phy), .o_leds(leds), .o_sw_rst(sw_rst),
      .o_sfp0_rs_pull_low(sfp0_rs), .o_sfp1_rs_pull_low(sfp1_rs)
   );

   task automatic compare(input string test, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         errors++;
         $display("error %s: expected 0x%08h, actual 0x%08h", test, exp, act);
      end
   endtask

   task automatic check_registers(input string test);
      compare({test, " leds"}, 32'(m_leds), 32'(leds));
      compare({test, " sw_rst"}, 32'(m_sw_rst), 32'(sw_rst));
      compare({test, " clock_control"}, 32'(m_clock_control), 32'(clock_control));
      compare({test, " sfp0_rs"}, 32'(m_sfp0_rs), 32'(sfp0_rs));
      compare({test, " sfp1_rs"}, 32'(m_sfp1_rs), 32'(sfp1_rs));
   endtask

   // Single strobe write with outputs checked one cycle later
   task automatic write_reg(input set_addr_t addr, input set_data_t data);
      @(posedge clk);
      set_stb <= 1'b1;
      set_addr <= addr;
      set_data <= data;
      @(posedge clk);
      set_stb <= 1'b0;
      case (addr)
         SR_LEDS:       m_leds = data[7:0];
         SR_SW_RST:     m_sw_rst = data[3:0];
         SR_CLOCK_CTRL: m_clock_control = data[7:0];
         SR_SFPP_CTRL0: m_sfp0_rs = data[1:0];
         SR_SFPP_CTRL1: m_sfp1_rs = data[1:0];
         default: ;
      endcase
      @(negedge clk);
      check_registers("random write");
   endtask

   task automatic read_word(input rb_addr_t addr, input logic stb, output rb_data_t data);
      @(posedge clk);
      rb_addr <= addr;
      rb_rd_stb <= stb;
      @(negedge clk);
      data = rb_data;
      @(posedge clk);
      rb_rd_stb <= 1'b0;
   endtask

   // Read one port's status word with an optional clearing strobe
   task automatic check_status(input string test, input int port, input logic clear);
      rb_data_t word;
      read_word((port == 0) ? RB_SFPP_STATUS0 : RB_SFPP_STATUS1, clear, word);
      compare(test, {m_phy[port], 10'b0, m_chgd[port], m_pins[port]}, word);
      if (clear) begin
         m_chgd[port] = '0;
      end
   endtask

   initial begin
      int cycles;
      int n;
      int port;
      rb_data_t word;
      rb_data_t first;
      clock_status_t cs;
      sfp_pins_t new_pins;
      phy_status_t new_phy;

      set_stb = 1'b0;
      set_addr = '0;
      set_data = '0;
      rb_rd_stb = 1'b0;
      rb_addr = '0;
      clock_status = '0;
      sfp0_pins = '0;
      sfp1_pins = '0;
      sfp0_phy = '0;
      sfp1_phy = '0;
      void'($urandom(SEED));

      cycles = 0;
      while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (arst_n !== 1'b1) begin
         errors++;
         $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
      end else begin
         @(negedge clk);
         check_registers("reset values");

         for (int i = 0; i < 60; i++) begin
            write_reg(($urandom_range(0, 3) == 0) ? set_addr_t'($urandom) :
                      SET_MAP[$urandom_range(0, 4)], $urandom);
         end

         // Constant words, clock status and unmapped addresses
         for (int i = 0; i < 8; i++) begin
            cs = clock_status_t'($urandom);
            @(posedge clk);
            clock_status <= cs;
            read_word(RB_CLK_STATUS, 1'b0, word);
            compare("clock status", {24'h0, cs}, word);
            read_word(RB_COMPAT_NUM, 1'b1, word);
            compare("compat number", 32'h0020_0000, word);
            read_word(rb_addr_t'($urandom) | 8'h10, 1'b1, word);
            compare("unknown address", 32'h0, word);
         end

         for (int i = 0; i < 6; i++) begin
            n = $urandom_range(1, 40);
            @(posedge clk);
            rb_addr <= RB_COUNTER;
            @(negedge clk);
            first = rb_data;
            repeat (n) @(negedge clk);
            compare("counter delta", 32'(n), rb_data - first);
         end

         // Pins held for 3 edges so the change latch has caught them
         for (int i = 0; i < 30; i++) begin
            port = $urandom_range(0, 1);
            new_pins = sfp_pins_t'($urandom);
            new_phy = phy_status_t'($urandom);
            @(posedge clk);
            if (port == 0) begin
               sfp0_pins <= new_pins;
               sfp0_phy <= new_phy;
            end else begin
               sfp1_pins <= new_pins;
               sfp1_phy <= new_phy;
            end
            m_chgd[port] = m_chgd[port] | (m_pins[port] ^ new_pins);
            m_pins[port] = new_pins;
            m_phy[port] = new_phy;
            repeat (3) @(posedge clk);
            check_status("sfp0 status", 0, 1'b0);
            check_status("sfp1 status", 1, 1'b0);
            if ($urandom_range(0, 1) == 1) begin
               check_status("sfp clearing read", port, 1'b1);
               check_status("sfp0 after clear", 0, 1'b0);
               check_status("sfp1 after clear", 1, 1'b0);
            end
         end
      end

      n = bus_ctrl_top_i.bus_ctrl_checker_i.fail_count;
      $display("Done: %0d check errors, %0d assertion failures", errors, n);
      if (errors + n == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
hdl/bus_map_pkg.sv
hdl/sfp_pkg.sv
hdl/sfp_status_if.sv
hdl/setting_regs.sv
hdl/sfp_monitor.sv
hdl/readback_mux.sv
hdl/bus_ctrl_top.sv
sim/tb_clkgen.sv
sim/bus_ctrl_checker.sv
sim/tb_top.sv

//--- Makefile
# Verilator flow for the bus control block and its testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
